// ==== Makefile ====
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= exec_cluster_tb
FILELIST   ?= all.f

OBJ_DIR  := obj_dir
SIM_BIN  := $(OBJ_DIR)/V$(TOP)
PASS_MSG := PASS: all tests
SOURCES  := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
verilog/exec_pkg.sv
verilog/exec_dispatch.sv
verilog/exec_lane.sv
verilog/cdb_arbiter.sv
verilog/exec_cluster.sv
dv/exec_cluster_tb.sv

// ==== dv/exec_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cluster_tb;

  localparam int NUM_LANES  = exec_pkg::NUM_LANES_DEF;
  localparam int DATA_W     = exec_pkg::DATA_W_DEF;
  localparam int TAG_W      = exec_pkg::TAG_W_DEF;
  localparam int NUM_TAGS   = 1 << TAG_W;
  localparam int WAIT_LIMIT = 200; // cycles allowed per wait loop

  logic              clk;
  logic              rst_n;
  logic              flush_i;
  logic              in_valid_i;
  exec_pkg::op_e     in_op_i;
  logic [DATA_W-1:0] in_a_i;
  logic [DATA_W-1:0] in_b_i;
  logic [TAG_W-1:0]  in_tag_i;
  logic              in_ready_o;
  logic              cdb_valid_o;
  logic [TAG_W-1:0]  cdb_tag_o;
  logic [DATA_W-1:0] cdb_data_o;

  // reference model with one slot per tag
  logic [DATA_W-1:0] expected [NUM_TAGS];
  logic              pending  [NUM_TAGS];
  logic              dropped  [NUM_TAGS];

  integer           seed;
  logic [TAG_W-1:0] next_tag;
  logic [TAG_W-1:0] last_tag;
  string            cur_test;
  int               err_cnt;
  int               num_tests;
  int               fail_tests;
  int               ooo_cnt;

  exec_cluster #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W),
    .TAG_W     (TAG_W)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_op_i     (in_op_i),
    .in_a_i      (in_a_i),
    .in_b_i      (in_b_i),
    .in_tag_i    (in_tag_i),
    .in_ready_o  (in_ready_o),
    .cdb_valid_o (cdb_valid_o),
    .cdb_tag_o   (cdb_tag_o),
    .cdb_data_o  (cdb_data_o)
  );

  always #50 clk = ~clk;

  function automatic logic [DATA_W-1:0] alu_model(input exec_pkg::op_e op,
                                                  input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
    logic [4:0] sh;
    sh = b[4:0]; // shifts use the low 5 bits only
    case (op)
      exec_pkg::OP_ADD: return a + b;
      exec_pkg::OP_SUB: return a - b;
      exec_pkg::OP_AND: return a & b;
      exec_pkg::OP_OR:  return a | b;
      exec_pkg::OP_XOR: return a ^ b;
      exec_pkg::OP_SLL: return a << sh;
      exec_pkg::OP_SRL: return a >> sh;
      exec_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? DATA_W'(1) : DATA_W'(0);
      default:          return '0;
    endcase
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (pending[t]) n++;
    end
    return n;
  endfunction

  function automatic int dropped_count();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      if (dropped[t]) n++;
    end
    return n;
  endfunction

  // scoreboard sampled at the rising edge where inputs and outputs are settled
  always @(posedge clk) begin
    if (rst_n) begin
      if (cdb_valid_o) begin
        assert (!dropped[cdb_tag_o]) else begin
          $display("error in %s: flushed tag %0d appeared on the CDB", cur_test, cdb_tag_o);
          err_cnt++;
        end
        assert (pending[cdb_tag_o] || dropped[cdb_tag_o]) else begin
          $display("error in %s: CDB result for tag %0d that is not pending", cur_test,
                   cdb_tag_o);
          err_cnt++;
        end
        if (pending[cdb_tag_o]) begin
          assert (cdb_data_o == expected[cdb_tag_o]) else begin
            $display("mismatch in %s: tag %0d expected %h actual %h", cur_test, cdb_tag_o,
                     expected[cdb_tag_o], cdb_data_o);
            err_cnt++;
          end
          pending[cdb_tag_o] <= 1'b0;
        end
        if (cdb_tag_o != TAG_W'(last_tag + 1'b1)) ooo_cnt <= ooo_cnt + 1;
        last_tag <= cdb_tag_o;
      end
      if (flush_i) begin
        assert (!in_ready_o) else begin
          $display("error in %s: in_ready_o was high during a flush", cur_test);
          err_cnt++;
        end
        for (int t = 0; t < NUM_TAGS; t++) begin
          if (pending[t] && !(cdb_valid_o && cdb_tag_o == TAG_W'(t))) begin
            dropped[t] <= 1'b1;
            pending[t] <= 1'b0;
          end
        end
      end
      if (in_valid_i && in_ready_o) begin
        assert (!pending[in_tag_i]) else begin
          $display("error in %s: tag %0d accepted while still pending", cur_test, in_tag_i);
          err_cnt++;
        end
        pending[in_tag_i]  <= 1'b1;
        expected[in_tag_i] <= alu_model(in_op_i, in_a_i, in_b_i);
      end
    end
  end

  // holds valid until accepted and returns on the accepting edge
  task automatic send_op(input exec_pkg::op_e op, input logic [DATA_W-1:0] a,
                         input logic [DATA_W-1:0] b);
    int cyc;
    bit acc;
    cyc = 0;
    while (pending[next_tag] && cyc < WAIT_LIMIT) begin
      in_valid_i <= 1'b0;
      @(posedge clk);
      cyc++;
    end
    assert (!pending[next_tag]) else begin
      $display("error in %s: tag %0d never became free", cur_test, next_tag);
      err_cnt++;
    end
    in_valid_i <= 1'b1;
    in_op_i    <= op;
    in_a_i     <= a;
    in_b_i     <= b;
    in_tag_i   <= next_tag;
    acc = 1'b0;
    cyc = 0;
    while (!acc && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
      acc = in_valid_i && in_ready_o;
    end
    assert (acc) else begin
      $display("error in %s: operation with tag %0d was never accepted", cur_test, next_tag);
      err_cnt++;
    end
    next_tag = TAG_W'(next_tag + 1'b1);
  endtask

  task automatic idle(input int n);
    in_valid_i <= 1'b0;
    repeat (n) @(posedge clk);
  endtask

  task automatic drain();
    int cyc;
    in_valid_i <= 1'b0;
    cyc = 0;
    @(posedge clk);
    while (pending_count() != 0 && cyc < WAIT_LIMIT) begin
      @(posedge clk);
      cyc++;
    end
    assert (pending_count() == 0) else begin
      $display("error in %s: %0d accepted operations never reached the CDB", cur_test,
               pending_count());
      err_cnt++;
    end
  endtask

  task automatic send_random(input int n_ops, input bit gaps);
    int                r;
    logic [2:0]        op_bits;
    logic [DATA_W-1:0] a;
    logic [DATA_W-1:0] b;
    for (int i = 0; i < n_ops; i++) begin
      r = $random(seed);
      if (gaps && (r & 3) == 0) idle(1 + ((r >> 2) & 3));
      op_bits = 3'($random(seed));
      a = DATA_W'($random(seed));
      b = DATA_W'($random(seed));
      send_op(exec_pkg::op_e'(op_bits), a, b);
    end
  endtask

  task automatic directed(input exec_pkg::op_e op, input logic [DATA_W-1:0] a,
                          input logic [DATA_W-1:0] b);
    send_op(op, a, b);
    drain();
  endtask

  task automatic end_test(input int err_start, input string note);
    num_tests++;
    if (err_cnt == err_start) begin
      $display("test %s: ok%s", cur_test, note);
    end else begin
      fail_tests++;
      $display("test %s: failed with %0d errors", cur_test, err_cnt - err_start);
    end
  endtask

  initial begin
    int err_start;
    int ooo_start;
    clk        = 1'b0;
    rst_n      = 1'b0;
    flush_i    = 1'b0;
    in_valid_i = 1'b0;
    in_op_i    = exec_pkg::OP_ADD;
    in_a_i     = '0;
    in_b_i     = '0;
    in_tag_i   = '0;
    seed       = 32'he256;
    next_tag   = '0;
    last_tag   = '1;
    err_cnt    = 0;
    num_tests  = 0;
    fail_tests = 0;
    ooo_cnt    = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      pending[t]  = 1'b0;
      dropped[t]  = 1'b0;
      expected[t] = '0;
    end

    cur_test = "reset";
    err_start = err_cnt;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    assert (cdb_valid_o == 1'b0) else begin
      $display("mismatch in %s: cdb_valid_o expected 0 actual %b", cur_test, cdb_valid_o);
      err_cnt++;
    end
    assert (in_ready_o == 1'b1) else begin
      $display("mismatch in %s: in_ready_o expected 1 actual %b", cur_test, in_ready_o);
      err_cnt++;
    end
    end_test(err_start, "");

    cur_test = "directed";
    err_start = err_cnt;
    directed(exec_pkg::OP_ADD, 32'd5, 32'd7);
    directed(exec_pkg::OP_ADD, 32'hffff_ffff, 32'd1); // wraps to 0
    directed(exec_pkg::OP_SUB, 32'd3, 32'd5);
    directed(exec_pkg::OP_AND, 32'hf0f0_f0f0, 32'hff00_ff00);
    directed(exec_pkg::OP_OR,  32'h0f0f_0f0f, 32'h00ff_00ff);
    directed(exec_pkg::OP_XOR, 32'haaaa_aaaa, 32'hffff_0000);
    directed(exec_pkg::OP_SLL, 32'h1234_5678, 32'd0);
    directed(exec_pkg::OP_SLL, 32'h0000_0001, 32'd31);
    directed(exec_pkg::OP_SLL, 32'h0000_0003, 32'hffff_ffe1); // upper b bits ignored
    directed(exec_pkg::OP_SRL, 32'h8765_4321, 32'd0);
    directed(exec_pkg::OP_SRL, 32'h8000_0000, 32'd31);
    directed(exec_pkg::OP_SLT, 32'hffff_ffff, 32'd1);
    directed(exec_pkg::OP_SLT, 32'd1, 32'hffff_ffff);
    directed(exec_pkg::OP_SLT, 32'hffff_fffb, 32'hffff_fffd);
    end_test(err_start, "");

    cur_test = "random";
    err_start = err_cnt;
    send_random(300, 1'b1);
    drain();
    end_test(err_start, "");

    cur_test = "burst";
    err_start = err_cnt;
    ooo_start = ooo_cnt;
    send_random(64, 1'b0);
    drain();
    end_test(err_start, $sformatf(", %0d results out of tag order", ooo_cnt - ooo_start));

    cur_test = "flush";
    err_start = err_cnt;
    send_random(6, 1'b0);
    in_valid_i <= 1'b0;
    flush_i    <= 1'b1;
    @(posedge clk);
    flush_i <= 1'b0;
    repeat (20) @(posedge clk); // watch window for flushed tags
    assert (dropped_count() > 0) else begin
      $display("error in %s: no operation was in flight when the flush was raised", cur_test);
      err_cnt++;
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      dropped[t] <= 1'b0;
    end
    send_random(40, 1'b1);
    drain();
    end_test(err_start, "");

    $display("tests: %0d run, %0d failed, %0d errors", num_tests, fail_tests, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/cdb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdb_arbiter #(
  parameter int NUM_LANES = 4,
  parameter int DATA_W    = 32,
  parameter int TAG_W     = 4
) (
  input  wire logic                              clk,
  input  wire logic                              rst_n,
  input  wire logic                              flush_i,
  input  wire logic [NUM_LANES-1:0]              res_valid_i,
  input  wire logic [NUM_LANES-1:0][TAG_W-1:0]   res_tag_i,
  input  wire logic [NUM_LANES-1:0][DATA_W-1:0]  res_data_i,
  output logic [NUM_LANES-1:0]                   res_grant_o,
  output logic                                   cdb_valid_o,
  output logic [TAG_W-1:0]                       cdb_tag_o,
  output logic [DATA_W-1:0]                      cdb_data_o
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] win_idx;
  logic             win_found;
  logic             grant;

  // round-robin search starting at the pointer
  always_comb begin
    int idx;
    win_found = 1'b0;
    win_idx   = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NUM_LANES) idx = idx - NUM_LANES;
      if (!win_found && res_valid_i[idx]) begin
        win_found = 1'b1;
        win_idx   = PTR_W'(idx);
      end
    end
  end

  assign grant = win_found && !flush_i;

  always_comb begin
    res_grant_o = '0;
    if (grant) res_grant_o[win_idx] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q       <= '0;
      cdb_valid_o <= 1'b0;
    end else begin
      cdb_valid_o <= grant; // flush leaves it low
      if (grant) begin
        if (win_idx == PTR_W'(NUM_LANES - 1)) ptr_q <= '0;
        else ptr_q <= win_idx + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (grant) begin
      cdb_tag_o  <= res_tag_i[win_idx];
      cdb_data_o <= res_data_i[win_idx];
    end
  end

  a_grant_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(res_grant_o) && ((res_grant_o & ~res_valid_i) == '0));

endmodule

`default_nettype wire

// ==== verilog/exec_cluster.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_cluster #(
  parameter int NUM_LANES = exec_pkg::NUM_LANES_DEF,
  parameter int DATA_W    = exec_pkg::DATA_W_DEF,
  parameter int TAG_W     = exec_pkg::TAG_W_DEF
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              flush_i,
  input  wire logic              in_valid_i,
  input  wire exec_pkg::op_e     in_op_i,
  input  wire logic [DATA_W-1:0] in_a_i,
  input  wire logic [DATA_W-1:0] in_b_i,
  input  wire logic [TAG_W-1:0]  in_tag_i,
  output logic                   in_ready_o,
  output logic                   cdb_valid_o,
  output logic [TAG_W-1:0]       cdb_tag_o,
  output logic [DATA_W-1:0]      cdb_data_o
);

  // dispatcher to lanes
  logic [NUM_LANES-1:0] lane_valid;
  logic [NUM_LANES-1:0] lane_ready;
  exec_pkg::op_e        lane_op;
  logic [DATA_W-1:0]    lane_a;
  logic [DATA_W-1:0]    lane_b;
  logic [TAG_W-1:0]     lane_tag;

  // lanes to arbiter
  logic [NUM_LANES-1:0]              res_valid;
  logic [NUM_LANES-1:0][TAG_W-1:0]   res_tag;
  logic [NUM_LANES-1:0][DATA_W-1:0]  res_data;
  logic [NUM_LANES-1:0]              res_grant;

  exec_dispatch #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W),
    .TAG_W     (TAG_W)
  ) u_dispatch (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .in_valid_i   (in_valid_i),
    .in_op_i      (in_op_i),
    .in_a_i       (in_a_i),
    .in_b_i       (in_b_i),
    .in_tag_i     (in_tag_i),
    .lane_ready_i (lane_ready),
    .in_ready_o   (in_ready_o),
    .lane_valid_o (lane_valid),
    .lane_op_o    (lane_op),
    .lane_a_o     (lane_a),
    .lane_b_o     (lane_b),
    .lane_tag_o   (lane_tag)
  );

  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    exec_lane #(
      .DATA_W (DATA_W),
      .TAG_W  (TAG_W)
    ) u_lane (
      .clk         (clk),
      .rst_n       (rst_n),
      .flush_i     (flush_i),
      .op_valid_i  (lane_valid[k]),
      .op_i        (lane_op),
      .a_i         (lane_a),
      .b_i         (lane_b),
      .tag_i       (lane_tag),
      .res_grant_i (res_grant[k]),
      .op_ready_o  (lane_ready[k]),
      .res_valid_o (res_valid[k]),
      .res_tag_o   (res_tag[k]),
      .res_data_o  (res_data[k])
    );
  end

  cdb_arbiter #(
    .NUM_LANES (NUM_LANES),
    .DATA_W    (DATA_W),
    .TAG_W     (TAG_W)
  ) u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .flush_i     (flush_i),
    .res_valid_i (res_valid),
    .res_tag_i   (res_tag),
    .res_data_i  (res_data),
    .res_grant_o (res_grant),
    .cdb_valid_o (cdb_valid_o),
    .cdb_tag_o   (cdb_tag_o),
    .cdb_data_o  (cdb_data_o)
  );

endmodule

`default_nettype wire

// ==== verilog/exec_dispatch.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_dispatch #(
  parameter int NUM_LANES = 4,
  parameter int DATA_W    = 32,
  parameter int TAG_W     = 4
) (
  input  wire logic                 clk,
  input  wire logic                 rst_n,
  input  wire logic                 flush_i,
  input  wire logic                 in_valid_i,
  input  wire exec_pkg::op_e        in_op_i,
  input  wire logic [DATA_W-1:0]    in_a_i,
  input  wire logic [DATA_W-1:0]    in_b_i,
  input  wire logic [TAG_W-1:0]     in_tag_i,
  input  wire logic [NUM_LANES-1:0] lane_ready_i,
  output logic                      in_ready_o,
  output logic [NUM_LANES-1:0]      lane_valid_o,
  output exec_pkg::op_e             lane_op_o,
  output logic [DATA_W-1:0]         lane_a_o,
  output logic [DATA_W-1:0]         lane_b_o,
  output logic [TAG_W-1:0]          lane_tag_o
);

  localparam int PTR_W = $clog2(NUM_LANES);

  logic [PTR_W-1:0] ptr_q;
  logic [PTR_W-1:0] sel_idx;
  logic             sel_found;
  logic             accept;

  // first ready lane at or after the pointer
  always_comb begin
    int idx;
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = 0; i < NUM_LANES; i++) begin
      idx = int'(ptr_q) + i;
      if (idx >= NUM_LANES) idx = idx - NUM_LANES;
      if (!sel_found && lane_ready_i[idx]) begin
        sel_found = 1'b1;
        sel_idx   = PTR_W'(idx);
      end
    end
  end

  assign in_ready_o = sel_found && !flush_i;
  assign accept     = in_valid_i && in_ready_o;

  always_comb begin
    lane_valid_o = '0;
    if (accept) lane_valid_o[sel_idx] = 1'b1;
  end

  // operation fields are shared, only the valid is steered
  assign lane_op_o  = in_op_i;
  assign lane_a_o   = in_a_i;
  assign lane_b_o   = in_b_i;
  assign lane_tag_o = in_tag_i;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (accept) begin
      if (sel_idx == PTR_W'(NUM_LANES - 1)) ptr_q <= '0;
      else ptr_q <= sel_idx + 1'b1;
    end
  end

  a_lane_valid_onehot : assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(lane_valid_o) && ((lane_valid_o & ~lane_ready_i) == '0));

endmodule

`default_nettype wire

// ==== verilog/exec_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_lane #(
  parameter int DATA_W = 32,
  parameter int TAG_W  = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,
  input  wire logic              flush_i,
  input  wire logic              op_valid_i,
  input  wire exec_pkg::op_e     op_i,
  input  wire logic [DATA_W-1:0] a_i,
  input  wire logic [DATA_W-1:0] b_i,
  input  wire logic [TAG_W-1:0]  tag_i,
  input  wire logic              res_grant_i,
  output logic                   op_ready_o,
  output logic                   res_valid_o,
  output logic [TAG_W-1:0]       res_tag_o,
  output logic [DATA_W-1:0]      res_data_o
);

  // stage 1, operation as accepted
  logic              s1_valid_q;
  exec_pkg::op_e     s1_op_q;
  logic [DATA_W-1:0] s1_a_q;
  logic [DATA_W-1:0] s1_b_q;
  logic [TAG_W-1:0]  s1_tag_q;

  // stage 2, tagged result waiting for the cdb
  logic              s2_valid_q;
  logic [TAG_W-1:0]  s2_tag_q;
  logic [DATA_W-1:0] s2_data_q;

  logic                        s2_free;
  logic                        s1_advance;
  logic                        accept;
  logic [DATA_W-1:0]           alu_res;
  logic [exec_pkg::SHAMT_W-1:0] shamt;

  assign s2_free    = !s2_valid_q || res_grant_i;
  assign s1_advance = s1_valid_q && s2_free;
  assign op_ready_o = !(s1_valid_q && !s2_free); // low only while stage 1 holds
  assign accept     = op_valid_i && op_ready_o;

  assign shamt = s1_b_q[exec_pkg::SHAMT_W-1:0];

  always_comb begin
    case (s1_op_q)
      exec_pkg::OP_ADD: alu_res = s1_a_q + s1_b_q;
      exec_pkg::OP_SUB: alu_res = s1_a_q - s1_b_q;
      exec_pkg::OP_AND: alu_res = s1_a_q & s1_b_q;
      exec_pkg::OP_OR:  alu_res = s1_a_q | s1_b_q;
      exec_pkg::OP_XOR: alu_res = s1_a_q ^ s1_b_q;
      exec_pkg::OP_SLL: alu_res = s1_a_q << shamt;
      exec_pkg::OP_SRL: alu_res = s1_a_q >> shamt;
      exec_pkg::OP_SLT: alu_res = {{(DATA_W-1){1'b0}}, $signed(s1_a_q) < $signed(s1_b_q)};
      default:          alu_res = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      s1_valid_q <= 1'b0;
    end else if (accept) begin
      s1_valid_q <= 1'b1;
    end else if (s1_advance) begin
      s1_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      s1_op_q  <= op_i;
      s1_a_q   <= a_i;
      s1_b_q   <= b_i;
      s1_tag_q <= tag_i;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      s2_valid_q <= 1'b0;
    end else if (s1_advance) begin
      s2_valid_q <= 1'b1;
    end else if (res_grant_i) begin
      s2_valid_q <= 1'b0; // result left on the cdb
    end
  end

  always_ff @(posedge clk) begin
    if (s1_advance) begin
      s2_tag_q  <= s1_tag_q;
      s2_data_q <= alu_res;
    end
  end

  assign res_valid_o = s2_valid_q;
  assign res_tag_o   = s2_tag_q;
  assign res_data_o  = s2_data_q;

  a_res_hold : assert property (@(posedge clk) disable iff (!rst_n)
    res_valid_o && !res_grant_i && !flush_i |=> $stable(res_tag_o) && $stable(res_data_o));

endmodule

`default_nettype wire

// ==== verilog/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // alu opcodes, 3 bit encoding
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5, // shift by b[4:0]
    OP_SRL = 3'd6, // logical, zero fill
    OP_SLT = 3'd7  // signed compare, 1 or 0
  } op_e;

  // shift amount taken from the low bits of operand b
  localparam int SHAMT_W = 5;

  // default operand and result width
  localparam int DATA_W_DEF = 32;

  // tag naming one operation in flight
  localparam int TAG_W_DEF = 4;

  // number of identical alu lanes
  localparam int NUM_LANES_DEF = 4;

endpackage

`default_nettype wire
